// File: Makefile
TOP = tb_periph_soc

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+rtl
rtl/periph_pkg.sv
rtl/sync_fifo.sv
rtl/uart_core.sv
rtl/uart_regs.sv
rtl/bus_decode.sv
rtl/board_io.sv
rtl/periph_soc.sv
verif/tb_periph_soc.sv

// File: rtl/board_io.sv
// board slot with LED register, DIP sampling and the seven-segment scanner
// LED and DIP words sit at fixed offsets in addr[7:3]
`timescale 1ns/1ps
`include "periph_macros.svh"

module board_io
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  periph_pkg::bus_req_t  req_i,
   output periph_pkg::bus_data_t rdata_o,
   input  periph_pkg::dip_t      from_dip_i,
   output periph_pkg::led_t      to_led_o,
   output logic [7:0]            an_o,
   output logic [7:0]            sseg_o
);

   localparam int SB = `PERIPH_SCAN_BITS;

   periph_pkg::led_t led_q;
   periph_pkg::dip_t dip_q;
   logic [SB-1:0]    scan_q;
   logic [2:0]       digit;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         led_q  <= '0;
         dip_q  <= '0;
         scan_q <= '0;
      end
      else
      begin
         dip_q  <= from_dip_i;   // sampled every cycle
         scan_q <= scan_q + 1'b1;
         if (req_i.en & (|req_i.we) & (req_i.addr[7:3] == 5'(`PERIPH_LED_OFS)))
            led_q <= req_i.wdata[21:0];
      end
   end

   always_comb
   begin
      case (req_i.addr[7:3])
         5'(`PERIPH_LED_OFS): rdata_o = {42'b0, led_q};
         5'(`PERIPH_DIP_OFS): rdata_o = {48'b0, dip_q};
         default:             rdata_o = '0;
      endcase
   end

   assign digit = scan_q[SB-1:SB-3];
   assign an_o  = ~(8'h80 >> digit);   // one anode low at a time

   always_comb
   begin
      case (digit)
         3'd0:    sseg_o = 8'hC7;
         3'd1:    sseg_o = 8'hC0;
         3'd2:    sseg_o = 8'hC1;
         3'd3:    sseg_o = 8'hC1;
         3'd4:    sseg_o = 8'hCE;
         3'd5:    sseg_o = 8'h86;
         3'd6:    sseg_o = 8'hC6;
         default: sseg_o = 8'h89;
      endcase
   end

   assign to_led_o = led_q;

endmodule

// File: rtl/bus_decode.sv
// slot decoder for the local bus
// gates en per slot and registers the read word one cycle after a read
`timescale 1ns/1ps
`include "periph_macros.svh"

module bus_decode
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  periph_pkg::bus_req_t  bus_i,
   output periph_pkg::bus_req_t  uart_req_o,
   output periph_pkg::bus_req_t  board_req_o,
   input  periph_pkg::bus_data_t uart_rdata_i,
   input  periph_pkg::bus_data_t board_rdata_i,
   output periph_pkg::bus_data_t rddata_o
);

   logic [2:0]            slot;
   logic                  rd;
   periph_pkg::bus_data_t rd_sel;
   periph_pkg::bus_data_t rddata_q;

   assign slot = bus_i.addr[17:15];
   assign rd   = bus_i.en & ~(|bus_i.we);   // no byte enables means read

   always_comb
   begin
      uart_req_o     = bus_i;
      uart_req_o.en  = bus_i.en & (slot == 3'(`PERIPH_SLOT_UART));
      board_req_o    = bus_i;
      board_req_o.en = bus_i.en & (slot == 3'(`PERIPH_SLOT_BOARD));
      case (slot)
         3'(`PERIPH_SLOT_UART):  rd_sel = uart_rdata_i;
         3'(`PERIPH_SLOT_BOARD): rd_sel = board_rdata_i;
         default:                rd_sel = '0;   // unmapped slot
      endcase
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         rddata_q <= '0;
      else if (rd)
         rddata_q <= rd_sel;   // held until the next read
   end

   assign rddata_o = rddata_q;

endmodule

// File: rtl/periph_macros.svh
// constants shared by the peripheral block RTL
// include wherever a baud, FIFO depth, slot number or register offset is needed
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// clock cycles per serial bit after reset
`define PERIPH_UBAUD_DEFAULT 54

// FIFO address bits, 16 entries
`define PERIPH_FIFO_AW 4

// slot numbers in addr[17:15]
`define PERIPH_SLOT_BOARD 2
`define PERIPH_SLOT_UART 6

// seven-segment scan counter width
`define PERIPH_SCAN_BITS 18

// board word offsets in addr[7:3]
`define PERIPH_LED_OFS 15
`define PERIPH_DIP_OFS 31

`endif

// File: rtl/periph_pkg.sv
// types of the peripheral block bus, UART and board I/O
// referenced by scoped name from every RTL module
package periph_pkg;

   typedef logic [17:0] bus_addr_t;
   typedef logic [63:0] bus_data_t;
   typedef logic [7:0]  byte_en_t;

   // one bus cycle from the core side
   typedef struct packed {
      logic      en;
      byte_en_t  we;     // all clear means read
      bus_addr_t addr;
      bus_data_t wdata;
   } bus_req_t;

   typedef logic [7:0]  uart_byte_t;
   typedef logic [8:0]  rx_word_t;     // error flag above the byte
   typedef logic [11:0] fifo_count_t;
   typedef logic [15:0] baud_t;

   typedef logic [21:0] led_t;
   typedef logic [15:0] dip_t;

   typedef enum logic [2:0] {
      UTX_IDLE,
      UTX_EMPTY,
      UTX_POP,
      UTX_START,
      UTX_INUSE
   } utx_state_t;

endpackage

// File: rtl/periph_soc.sv
// low-speed peripheral block top level
// connects the bus decoder, UART slot and board I/O slot to the pins
`timescale 1ns/1ps

module periph_soc
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  periph_pkg::bus_req_t  bus_i,
   output periph_pkg::bus_data_t rddata_o,
   input  logic                  uart_rx_i,
   output logic                  uart_tx_o,
   output logic                  uart_irq_o,
   input  periph_pkg::dip_t      from_dip_i,
   output periph_pkg::led_t      to_led_o,
   output logic [7:0]            an_o,
   output logic [7:0]            sseg_o
);

   periph_pkg::bus_req_t  uart_req;
   periph_pkg::bus_req_t  board_req;
   periph_pkg::bus_data_t uart_rdata;
   periph_pkg::bus_data_t board_rdata;

   bus_decode u_decode (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .bus_i         (bus_i),
      .uart_req_o    (uart_req),
      .board_req_o   (board_req),
      .uart_rdata_i  (uart_rdata),
      .board_rdata_i (board_rdata),
      .rddata_o      (rddata_o)
   );

   uart_regs u_uart (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .req_i      (uart_req),
      .rdata_o    (uart_rdata),
      .uart_rx_i  (uart_rx_i),
      .uart_tx_o  (uart_tx_o),
      .uart_irq_o (uart_irq_o)
   );

   board_io u_board (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .req_i      (board_req),
      .rdata_o    (board_rdata),
      .from_dip_i (from_dip_i),
      .to_led_o   (to_led_o),
      .an_o       (an_o),
      .sseg_o     (sseg_o)
   );

endmodule

// File: rtl/sync_fifo.sv
// show-ahead synchronous FIFO with free-running pointer counts
// used for the UART transmit and receive queues
`timescale 1ns/1ps
`include "periph_macros.svh"

module sync_fifo #(
   parameter int WIDTH = 8
)
(
   input  logic                     msoc_clk,
   input  logic                     rstn,
   input  logic [WIDTH-1:0]         din_i,
   input  logic                     wr_en_i,
   input  logic                     rd_en_i,
   output logic [WIDTH-1:0]         dout_o,
   output logic                     full_o,
   output logic                     empty_o,
   output periph_pkg::fifo_count_t  wrcount_o,
   output periph_pkg::fifo_count_t  rdcount_o
);

   localparam int AW = `PERIPH_FIFO_AW;
   localparam periph_pkg::fifo_count_t DEPTH = periph_pkg::fifo_count_t'(1 << AW);

   logic [WIDTH-1:0]        mem [DEPTH];
   periph_pkg::fifo_count_t wr_ptr_q;
   periph_pkg::fifo_count_t rd_ptr_q;
   periph_pkg::fifo_count_t level;
   logic                    do_wr;
   logic                    do_rd;

   // pointers wrap at 4096, a multiple of the depth
   assign level   = wr_ptr_q - rd_ptr_q;
   assign full_o  = (level == DEPTH);
   assign empty_o = (level == '0);
   assign do_wr   = wr_en_i & ~full_o;    // ignored when full
   assign do_rd   = rd_en_i & ~empty_o;   // ignored when empty

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 12'd1;
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 12'd1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (do_wr)
         mem[wr_ptr_q[AW-1:0]] <= din_i;
   end

   assign dout_o    = mem[rd_ptr_q[AW-1:0]];   // head visible without a read
   assign wrcount_o = wr_ptr_q;
   assign rdcount_o = rd_ptr_q;

endmodule

// File: rtl/uart_core.sv
// baud-timed serializer and deserializer, 8N1 LSB first
// receive line goes through a three-sample majority filter
`timescale 1ns/1ps

module uart_core
(
   input  logic                   msoc_clk,
   input  logic                   rstn,
   input  periph_pkg::baud_t      baud_i,
   input  logic                   start_i,
   input  periph_pkg::uart_byte_t tx_byte_i,
   output logic                   busy_o,
   input  logic                   rx_i,
   output logic                   rx_valid_o,
   output periph_pkg::rx_word_t   rx_word_o,
   output logic                   tx_o
);

   logic                   tx_q;
   logic                   tx_busy_q;
   logic [8:0]             tx_sh_q;     // data then stop bit
   logic [3:0]             tx_left_q;
   periph_pkg::baud_t      tx_tmr_q;

   logic [2:0]             rx_s_q;
   logic                   rx_maj;
   logic                   rx_busy_q;
   logic [3:0]             rx_left_q;
   periph_pkg::baud_t      rx_tmr_q;
   periph_pkg::uart_byte_t rx_sh_q;
   logic                   rx_valid_q;
   periph_pkg::rx_word_t   rx_word_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_q      <= 1'b1;   // line idles high
         tx_busy_q <= 1'b0;
         tx_sh_q   <= '1;
         tx_left_q <= '0;
         tx_tmr_q  <= '0;
      end
      else if (tx_busy_q)
      begin
         if (tx_tmr_q == '0)
         begin
            tx_tmr_q <= baud_i - 16'd1;
            if (tx_left_q == '0)
               tx_busy_q <= 1'b0;   // stop bit done
            else
            begin
               tx_q      <= tx_sh_q[0];
               tx_sh_q   <= {1'b1, tx_sh_q[8:1]};
               tx_left_q <= tx_left_q - 4'd1;
            end
         end
         else
            tx_tmr_q <= tx_tmr_q - 16'd1;
      end
      else if (start_i)
      begin
         tx_q      <= 1'b0;   // start bit
         tx_sh_q   <= {1'b1, tx_byte_i};
         tx_left_q <= 4'd9;
         tx_tmr_q  <= baud_i - 16'd1;
         tx_busy_q <= 1'b1;
      end
   end

   assign rx_maj = (rx_s_q[0] & rx_s_q[1]) | (rx_s_q[0] & rx_s_q[2]) | (rx_s_q[1] & rx_s_q[2]);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_s_q     <= 3'b111;
         rx_busy_q  <= 1'b0;
         rx_left_q  <= '0;
         rx_tmr_q   <= '0;
         rx_sh_q    <= '0;
         rx_valid_q <= 1'b0;
         rx_word_q  <= '0;
      end
      else
      begin
         rx_s_q     <= {rx_s_q[1:0], rx_i};
         rx_valid_q <= 1'b0;
         if (!rx_busy_q)
         begin
            if (!rx_maj)
            begin
               rx_busy_q <= 1'b1;
               rx_left_q <= 4'd10;
               rx_tmr_q  <= {1'b0, baud_i[15:1]};   // half a bit to mid start
            end
         end
         else if (rx_tmr_q != '0)
            rx_tmr_q <= rx_tmr_q - 16'd1;
         else
         begin
            rx_tmr_q  <= baud_i - 16'd1;
            rx_left_q <= rx_left_q - 4'd1;
            if (rx_left_q == 4'd10)
            begin
               if (rx_maj)
                  rx_busy_q <= 1'b0;   // glitch, not a start bit
            end
            else if (rx_left_q == 4'd1)
            begin
               rx_word_q  <= {~rx_maj, rx_sh_q};   // low stop bit flags an error
               rx_valid_q <= 1'b1;
               rx_busy_q  <= 1'b0;
            end
            else
               rx_sh_q <= {rx_maj, rx_sh_q[7:1]};
         end
      end
   end

   assign busy_o     = tx_busy_q;
   assign tx_o       = tx_q;
   assign rx_valid_o = rx_valid_q;
   assign rx_word_o  = rx_word_q;

endmodule

// File: rtl/uart_regs.sv
// UART slot registers, transmit sequencer and interrupt
// holds the baud divisor and both FIFOs around the serial core
`timescale 1ns/1ps
`include "periph_macros.svh"

module uart_regs
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  periph_pkg::bus_req_t  req_i,
   output periph_pkg::bus_data_t rdata_o,
   input  logic                  uart_rx_i,
   output logic                  uart_tx_o,
   output logic                  uart_irq_o
);

   logic                    wr;
   logic                    tx_push;
   logic                    rx_pop;
   periph_pkg::baud_t       baud_q;
   periph_pkg::utx_state_t  state_q;
   periph_pkg::utx_state_t  state_d;
   periph_pkg::uart_byte_t  tx_head;
   periph_pkg::uart_byte_t  tx_byte_q;
   logic                    tx_full, tx_empty, rx_full, rx_empty;
   periph_pkg::fifo_count_t tx_wrcount, tx_rdcount, rx_wrcount, rx_rdcount;
   periph_pkg::rx_word_t    rx_head;
   periph_pkg::rx_word_t    rx_word;
   logic                    rx_valid;
   logic                    tx_busy;
   logic                    irq_q;

   assign wr      = req_i.en & (|req_i.we) & req_i.addr[14];
   assign tx_push = wr & (req_i.addr[13:12] == 2'b00);
   assign rx_pop  = wr & (req_i.addr[13:12] == 2'b01);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q  <= periph_pkg::baud_t'(`PERIPH_UBAUD_DEFAULT);
         state_q <= periph_pkg::UTX_IDLE;
         irq_q   <= 1'b0;
      end
      else
      begin
         if (wr & (req_i.addr[13:12] == 2'b10))
            baud_q <= req_i.wdata[15:0];
         state_q <= state_d;
         irq_q   <= ~rx_empty;   // one cycle behind the push
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         periph_pkg::UTX_IDLE:  state_d = periph_pkg::UTX_EMPTY;
         periph_pkg::UTX_EMPTY: if (!tx_empty) state_d = periph_pkg::UTX_POP;
         periph_pkg::UTX_POP:   state_d = periph_pkg::UTX_START;
         periph_pkg::UTX_START: state_d = periph_pkg::UTX_INUSE;
         periph_pkg::UTX_INUSE: if (!tx_busy) state_d = periph_pkg::UTX_IDLE;
         default:               state_d = periph_pkg::UTX_IDLE;
      endcase
   end

   // the head moves on at the pop so keep a copy for the start pulse
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == periph_pkg::UTX_POP)
         tx_byte_q <= tx_head;
   end

   sync_fifo #(.WIDTH(8)) u_tx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .din_i    (req_i.wdata[7:0]),
      .wr_en_i  (tx_push),
      .rd_en_i  (state_q == periph_pkg::UTX_POP),
      .dout_o   (tx_head),
      .full_o   (tx_full),
      .empty_o  (tx_empty),
      .wrcount_o(tx_wrcount),
      .rdcount_o(tx_rdcount)
   );

   sync_fifo #(.WIDTH(9)) u_rx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .din_i    (rx_word),
      .wr_en_i  (rx_valid),   // dropped by the FIFO when full
      .rd_en_i  (rx_pop),
      .dout_o   (rx_head),
      .full_o   (rx_full),
      .empty_o  (rx_empty),
      .wrcount_o(rx_wrcount),
      .rdcount_o(rx_rdcount)
   );

   uart_core u_core (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud_q),
      .start_i    (state_q == periph_pkg::UTX_START),
      .tx_byte_i  (tx_byte_q),
      .busy_o     (tx_busy),
      .rx_i       (uart_rx_i),
      .rx_valid_o (rx_valid),
      .rx_word_o  (rx_word),
      .tx_o       (uart_tx_o)
   );

   always_comb
   begin
      if (!req_i.addr[14])
         rdata_o = '0;   // former keyboard words
      else if (req_i.addr[13])
         rdata_o = {4'b0, tx_wrcount, 4'b0, tx_rdcount, 4'b0, rx_wrcount, 4'b0, rx_rdcount};
      else
         rdata_o = {52'b0, rx_full, tx_full, rx_empty, rx_head};
   end

   assign uart_irq_o = irq_q;

endmodule

// File: verif/tb_periph_soc.sv
// testbench for the peripheral block with bus traffic, UART loopback and scanner checks
// built and run by the Makefile test target
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph_soc;

   localparam int MAX_BAUD       = 16;
   localparam int SERIAL_BYTES   = 16 + 4 + 17;   // burst, single bytes, overflow
   localparam int SCAN_CYCLES    = 1 << `PERIPH_SCAN_BITS;
   localparam int TIMEOUT_CYCLES = SERIAL_BYTES * 10 * MAX_BAUD * 2 + SCAN_CYCLES + 2000;

   logic                  msoc_clk;
   logic                  rstn;
   periph_pkg::bus_req_t  bus_i;
   periph_pkg::bus_data_t rddata_o;
   logic                  tx_line;   // tx looped back into rx
   logic                  uart_irq_o;
   periph_pkg::dip_t      from_dip_i;
   periph_pkg::led_t      to_led_o;
   logic [7:0]            an_o;
   logic [7:0]            sseg_o;

   int         cur_baud = `PERIPH_UBAUD_DEFAULT;
   int         mismatch_cnt = 0;
   int         other_cnt = 0;
   int         cycle_cnt = 0;
   int         tx_wr = 0;   // model of the four FIFO counts
   int         tx_rd = 0;
   int         rx_wr = 0;
   int         rx_rd = 0;
   logic [7:0] exp_q[$];    // bytes the line must carry, in order
   logic [7:0] seg_table [8] = '{8'hC7, 8'hC0, 8'hC1, 8'hC1, 8'hCE, 8'h86, 8'hC6, 8'h89};

   periph_soc dut0 (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .bus_i      (bus_i),
      .rddata_o   (rddata_o),
      .uart_rx_i  (tx_line),
      .uart_tx_o  (tx_line),
      .uart_irq_o (uart_irq_o),
      .from_dip_i (from_dip_i),
      .to_led_o   (to_led_o),
      .an_o       (an_o),
      .sseg_o     (sseg_o)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever #20 msoc_clk = ~msoc_clk;
   end

   always @(posedge msoc_clk)
   begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT_CYCLES)
      begin
         $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic log_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
      mismatch_cnt++;
      $display("ERR %s exp=%0h act=%0h", name, exp, act);
   endtask

   task automatic log_other(input string msg);
      other_cnt++;
      $display("error: %s", msg);
   endtask

   function automatic periph_pkg::bus_req_t make_req(input periph_pkg::byte_en_t we,
                                                     input periph_pkg::bus_addr_t addr,
                                                     input periph_pkg::bus_data_t data);
      periph_pkg::bus_req_t req;
      req.en    = 1'b1;
      req.we    = we;
      req.addr  = addr;
      req.wdata = data;
      return req;
   endfunction

   function automatic periph_pkg::bus_addr_t uart_addr(input logic [1:0] sel);
      return {3'(`PERIPH_SLOT_UART), 1'b1, sel, 12'h000};
   endfunction

   function automatic periph_pkg::bus_addr_t board_addr(input int ofs);
      return {3'(`PERIPH_SLOT_BOARD), 7'h00, 5'(ofs), 3'b000};
   endfunction

   // four count lanes with the tx write count on top
   function automatic periph_pkg::bus_data_t count_word();
      return {4'b0, 12'(tx_wr), 4'b0, 12'(tx_rd), 4'b0, 12'(rx_wr), 4'b0, 12'(rx_rd)};
   endfunction

   task automatic write_word(input periph_pkg::bus_addr_t addr,
                             input periph_pkg::bus_data_t data);
      @(posedge msoc_clk);
      bus_i <= make_req(8'($urandom) | 8'h01, addr, data);   // any enable set is a write
   endtask

   task automatic bus_idle();
      @(posedge msoc_clk);
      bus_i <= '0;
   endtask

   task automatic read_word(input periph_pkg::bus_addr_t addr,
                            output periph_pkg::bus_data_t data);
      @(posedge msoc_clk);
      bus_i <= make_req(8'h00, addr, {$urandom, $urandom});
      @(posedge msoc_clk);
      bus_i <= '0;
      @(negedge msoc_clk);
      data = rddata_o;   // one cycle after the request
   endtask

   // serial line model decoding 8N1 at the current divisor
   initial
   begin : line_model
      logic [7:0] data;
      logic [7:0] want;
      wait (rstn === 1'b1);
      forever
      begin
         @(negedge tx_line);
         repeat (cur_baud / 2) @(negedge msoc_clk);
         if (tx_line !== 1'b0)
            log_other("tx line start bit did not stay low to mid-bit");
         else
         begin
            for (int i = 0; i < 8; i++)
            begin
               repeat (cur_baud) @(negedge msoc_clk);
               data[i] = tx_line;   // lsb first
            end
            repeat (cur_baud) @(negedge msoc_clk);
            if (tx_line !== 1'b1)
               log_other("tx line stop bit sampled low");
            if (exp_q.size() == 0)
               log_other("tx line carried a byte that was never queued");
            else
            begin
               want = exp_q.pop_front();
               if (data !== want)
                  log_mismatch("tx_line", 64'(want), 64'(data));
            end
         end
      end
   end

   initial
   begin
      periph_pkg::bus_data_t rd;
      periph_pkg::bus_data_t wd;
      periph_pkg::bus_data_t exp_rd;
      periph_pkg::dip_t      dip;
      logic [7:0]            b;
      logic [7:0]            burst_q[$];
      logic [2:0]            unmapped [6];
      logic [7:0]            seen;
      int                    n_burst;
      int                    zeros;
      int                    k;
      int                    tx_base;

      rstn = 1'b0;
      bus_i = '0;
      from_dip_i = '0;
      unmapped = '{3'd0, 3'd1, 3'd3, 3'd4, 3'd5, 3'd7};
      void'($urandom(32'hb365_3433));
      repeat (16) @(posedge msoc_clk);
      rstn <= 1'b1;
      @(negedge msoc_clk);

      // reset values
      if (tx_line !== 1'b1)
         log_mismatch("reset_tx", 64'd1, 64'(tx_line));
      if (uart_irq_o !== 1'b0)
         log_mismatch("reset_irq", 64'd0, 64'(uart_irq_o));
      if (to_led_o !== '0)
         log_mismatch("reset_led", 64'd0, 64'(to_led_o));
      if (rddata_o !== '0)
         log_mismatch("reset_rddata", 64'd0, rddata_o);
      if (an_o !== 8'h7F)
         log_mismatch("reset_an", 64'h7F, 64'(an_o));
      read_word(uart_addr(2'b00), rd);
      if (rd[63:9] !== 55'd1)
         log_mismatch("reset_status", 64'd1, 64'(rd[63:9]));
      read_word(uart_addr(2'b10), rd);
      if (rd !== '0)
         log_mismatch("reset_counts", 64'd0, rd);

      // board slot
      for (int i = 0; i < 4; i++)
      begin
         wd = {$urandom, $urandom};
         write_word(board_addr(`PERIPH_LED_OFS), wd);
         bus_idle();
         @(negedge msoc_clk);
         if (to_led_o !== wd[21:0])
            log_mismatch("led_pins", 64'(wd[21:0]), 64'(to_led_o));
         read_word(board_addr(`PERIPH_LED_OFS), rd);
         if (rd !== 64'(wd[21:0]))
            log_mismatch("led_read", 64'(wd[21:0]), rd);
         dip = 16'($urandom);
         @(posedge msoc_clk);
         from_dip_i <= dip;
         read_word(board_addr(`PERIPH_DIP_OFS), rd);
         if (rd !== 64'(dip))
            log_mismatch("dip_read", 64'(dip), rd);
         read_word({unmapped[$urandom % 6], 15'($urandom)}, rd);
         if (rd !== '0)
            log_mismatch("unmapped_read", 64'd0, rd);
      end

      // transmit burst at a short divisor
      cur_baud = 8 + int'($urandom % 9);
      write_word(uart_addr(2'b10), 64'(cur_baud));
      bus_idle();
      n_burst = 1 + int'($urandom % 16);
      for (int i = 0; i < n_burst; i++)
      begin
         b = 8'($urandom);
         burst_q.push_back(b);
         exp_q.push_back(b);
         write_word(uart_addr(2'b00), {56'($urandom), b});
      end
      bus_idle();
      tx_wr += n_burst;
      tx_rd += n_burst;
      rx_wr += n_burst;
      while (exp_q.size() != 0)
         @(negedge msoc_clk);
      rd = '0;
      while (rd[27:16] !== 12'(rx_wr))   // last loopback byte lands in the rx FIFO
         read_word(uart_addr(2'b10), rd);
      if (rd !== count_word())
         log_mismatch("tx_counts", count_word(), rd);

      // receive by loopback
      foreach (burst_q[i])
      begin
         exp_rd = {52'd0, ((n_burst - i) == 16), 3'b000, burst_q[i]};   // full with 16 queued
         read_word(uart_addr(2'b00), rd);
         if (rd !== exp_rd)
            log_mismatch("rx_pop", exp_rd, rd);
         write_word(uart_addr(2'b01), 64'($urandom));
         rx_rd++;
      end
      bus_idle();
      read_word(uart_addr(2'b00), rd);
      if (rd[63:9] !== 55'd1)
         log_mismatch("rx_drained", 64'd1, 64'(rd[63:9]));
      if (uart_irq_o !== 1'b0)
         log_mismatch("irq_after_drain", 64'd0, 64'(uart_irq_o));
      for (int i = 0; i < 4; i++)
      begin
         b = 8'($urandom);
         exp_q.push_back(b);
         write_word(uart_addr(2'b00), 64'(b));
         bus_idle();
         while (uart_irq_o !== 1'b1)
            @(negedge msoc_clk);
         read_word(uart_addr(2'b00), rd);
         if (rd !== {56'd0, b})
            log_mismatch("rx_single", {56'd0, b}, rd);
         write_word(uart_addr(2'b01), 64'($urandom));
         bus_idle();
         while (uart_irq_o !== 1'b0)
            @(negedge msoc_clk);
      end
      tx_wr += 4;
      tx_rd += 4;
      rx_wr += 4;
      rx_rd += 4;
      read_word(uart_addr(2'b10), rd);
      if (rd !== count_word())
         log_mismatch("rx_counts", count_word(), rd);

      // overflow with a lead byte keeping the sequencer busy so the FIFO fills
      b = 8'($urandom);
      exp_q.push_back(b);
      write_word(uart_addr(2'b00), 64'(b));
      bus_idle();
      while (tx_line !== 1'b0)
         @(negedge msoc_clk);
      tx_base = tx_wr + 1;
      for (int i = 0; i < 20; i++)
      begin
         b = 8'($urandom);
         if (i < 16)
            exp_q.push_back(b);
         write_word(uart_addr(2'b00), 64'(b));
      end
      bus_idle();
      read_word(uart_addr(2'b00), rd);
      if (rd[10] !== 1'b1)
         log_mismatch("tx_full", 64'd1, 64'(rd[10]));
      read_word(uart_addr(2'b10), rd);
      if (rd[59:48] !== 12'(tx_base + 16))
         log_mismatch("overflow_wrcount", 64'(tx_base + 16), 64'(rd[59:48]));
      while (exp_q.size() != 0)
         @(negedge msoc_clk);

      // seven-segment scan over one full period
      seen = '0;
      for (int i = 0; i < SCAN_CYCLES; i++)
      begin
         @(negedge msoc_clk);
         zeros = 0;
         k = 0;
         for (int j = 0; j < 8; j++)
         begin
            if (an_o[j] === 1'b0)
            begin
               zeros++;
               k = 7 - j;
            end
         end
         if (zeros != 1)
            log_other($sformatf("an_o %b does not select exactly one digit", an_o));
         else if (sseg_o !== seg_table[k])
            log_mismatch("scan_sseg", 64'(seg_table[k]), 64'(sseg_o));
         seen[k] = 1'b1;
      end
      if (seen !== 8'hFF)
         log_mismatch("scan_digits", 64'hFF, 64'(seen));

      $display("errors: %0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
